/* all.f */
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/pipe_stage.sv
hdl/alu_execute.sv
hdl/cpu_core.sv
sim/cpu_core_sva.sv
sim/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_cpu_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_cpu_core.sv */
// Self-checking testbench for cpu_core.
// A sequential register model predicts every write-back in issue order.
// Outputs are sampled on the falling edge, and inputs change on the rising edge.
// The run is bounded by a cycle limit that follows from the test lengths.

`timescale 1ns/1ps

module tb_cpu_core;

   import cpu_pkg::*;

   typedef struct packed {
      reg_idx_t idx;
      word_t    data;
   } exp_t;

   // Slots per test, used for the cycle limit
   localparam int LOAD_SLOTS     = 16;
   localparam int ALU_SLOTS      = 120;
   localparam int CMP_SLOTS      = 49;
   localparam int STALL_INSTRS   = 80;
   localparam int MISC_SLOTS     = 52;
   localparam int DRAIN_SLOTS    = 72;
   localparam int MAX_STALLS     = STALL_INSTRS * 3;
   localparam int TIMEOUT_CYCLES = 4 * (LOAD_SLOTS + ALU_SLOTS + CMP_SLOTS + STALL_INSTRS
                                   + MISC_SLOTS + DRAIN_SLOTS + MAX_STALLS) + 100;

   logic     clk;
   logic     arst_n;
   logic     instr_valid;
   instr_t   instr;
   logic     stall;
   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;

   integer   seed = 32'hbc00;
   word_t    ref_regs [8];
   exp_t     exp_q [$];
   exp_t     exp_head;
   reg_idx_t dep1 = 3'd0;
   reg_idx_t dep2 = 3'd0;
   int       error_count = 0;
   int       check_count = 0;
   int       test_errors = 0;
   int       test_checks = 0;
   int       cycle_count = 0;

   // Signed pairs for the compares
   word_t cmp_a [7] = '{16'd5, 16'hfffd, 16'd7, 16'h8000, 16'h7fff, 16'h8000, 16'hffff};
   word_t cmp_b [7] = '{16'd5, 16'd7, 16'hfffd, 16'h7fff, 16'h8000, 16'h8000, 16'h0000};
   logic [4:0] bad_ops [6] = '{5'b00000, 5'b00010, 5'b00111, 5'b01111, 5'b10000, 5'b11111};

   cpu_core i_cpu_core (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .stall       (stall),
      .wb_valid    (wb_valid),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic instr_t make_rtype(input logic [4:0] op, input reg_idx_t rs,
                                         input reg_idx_t rt, input reg_idx_t rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic instr_t make_itype(input logic [4:0] op, input reg_idx_t rs,
                                         input reg_idx_t rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic instr_t make_btype(input logic [4:0] op, input reg_idx_t rs,
                                         input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   // Architectural model, one instruction at a time
   function automatic void predict(input instr_t ins);
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      word_t    a;
      word_t    b;
      word_t    res;
      logic     wr;
      exp_t     e;
      rs  = ins[10:8];
      rt  = ins[7:5];
      rd  = ins[4:2];
      a   = ref_regs[rs];
      b   = ref_regs[rt];
      wr  = 1'b1;
      res = '0;
      case (ins[15:11])
         OP_ADD:  res = a + b;
         OP_SUB:  res = b - a;
         OP_XOR:  res = a ^ b;
         OP_ANDN: res = a & ~b;
         OP_SEQ:  res = (a == b) ? 16'd1 : 16'd0;
         OP_SLT:  res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         OP_SLE:  res = ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0;
         OP_ADDI: begin
            rd  = rt;
            res = a + {{11{ins[4]}}, ins[4:0]};
         end
         OP_LBI: begin
            rd  = rs;
            res = {{8{ins[7]}}, ins[7:0]};
         end
         OP_SLBI: begin
            rd  = rs;
            res = {a[7:0], ins[7:0]};
         end
         default: wr = 1'b0;
      endcase
      if (wr) begin
         ref_regs[rd] = res;
         e.idx  = rd;
         e.data = res;
         exp_q.push_back(e);
      end
   endfunction

   // Random ALU op, often reading the last one or two destinations
   function automatic instr_t random_alu();
      logic [31:0] r;
      logic [4:0]  op;
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      r = next_rand();
      case (r[2:0])
         3'd0, 3'd5: op = OP_ADD;
         3'd1, 3'd6: op = OP_SUB;
         3'd2:       op = OP_XOR;
         3'd3:       op = OP_ANDN;
         default:    op = OP_ADDI;
      endcase
      rs   = r[3] ? dep1 : r[6:4];
      rt   = r[7] ? dep2 : r[10:8];
      rd   = r[13:11];
      dep2 = dep1;
      dep1 = rd;
      if (op == OP_ADDI) begin
         return make_itype(op, rs, rd, r[20:16]);
      end
      return make_rtype(op, rs, rt, rd);
   endfunction

   task automatic check_reg(input reg_idx_t got, input reg_idx_t exp);
      check_count++;
      test_checks++;
      if (got !== exp) begin
         $display("error at %0t: wb_reg is %0d, expected %0d", $time, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic check_word(input word_t got, input word_t exp);
      check_count++;
      test_checks++;
      if (got !== exp) begin
         $display("error at %0t: wb_data is %h, expected %h", $time, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   // Holds the instruction through stall_cycles stalled cycles
   task automatic issue(input instr_t ins, input logic valid, input int stall_cycles);
      for (int i = 0; i < stall_cycles; i++) begin
         @(posedge clk);
         instr       <= ins;
         instr_valid <= valid;
         stall       <= 1'b1;
      end
      @(posedge clk);
      instr       <= ins;
      instr_valid <= valid;
      stall       <= 1'b0;
      if (valid) begin
         predict(ins);
      end
   endtask

   task automatic load_reg(input reg_idx_t r, input word_t v);
      issue(make_btype(OP_LBI, r, v[15:8]), 1'b1, 0);
      issue(make_btype(OP_SLBI, r, v[7:0]), 1'b1, 0);
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 12) begin
         issue('0, 1'b0, 0);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("Missing write-backs at %0t: %0d results never appeared",
                  $time, exp_q.size());
         error_count++;
         test_errors++;
         exp_q.delete();
      end
   endtask

   task automatic end_test(input string name);
      drain();
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // Compare process
   always @(negedge clk) begin
      if (arst_n && wb_valid) begin
         if (stall) begin
            $display("Write-back seen at %0t while stall was high", $time);
            error_count++;
            test_errors++;
         end
         if (exp_q.size() == 0) begin
            $display("Unexpected write-back at %0t to register %0d", $time, wb_reg);
            error_count++;
            test_errors++;
         end else begin
            exp_head = exp_q.pop_front();
            check_reg(wb_reg, exp_head.idx);
            check_word(wb_data, exp_head.data);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin : main_seq
      logic [31:0] r;
      int          n;
      arst_n      = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      stall       = 1'b0;
      for (int i = 0; i < 8; i++) begin
         ref_regs[i] = '0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // Quiet after reset, then first write-back latency
      repeat (5) issue('0, 1'b0, 0);
      issue(make_btype(OP_LBI, 3'd0, 8'h5a), 1'b1, 0);
      @(posedge clk);
      instr_valid <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_valid && n < 8);
      if (!wb_valid) begin
         $display("No write-back appeared after the first LBI");
         error_count++;
         test_errors++;
      end else if (n != 2) begin
         $display("error at %0t: write-back after %0d cycles, expected 2", $time, n);
         error_count++;
         test_errors++;
      end
      end_test("reset_latency");

      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         load_reg(reg_idx_t'(i), r[15:0]);
      end
      end_test("byte_loads");

      for (int i = 0; i < ALU_SLOTS; i++) begin
         issue(random_alu(), 1'b1, 0);
      end
      end_test("alu_forwarding");

      for (int i = 0; i < 7; i++) begin
         load_reg(3'd1, cmp_a[i]);
         load_reg(3'd2, cmp_b[i]);
         issue(make_rtype(OP_SEQ, 3'd1, 3'd2, 3'd3), 1'b1, 0);
         issue(make_rtype(OP_SLT, 3'd1, 3'd2, 3'd4), 1'b1, 0);
         issue(make_rtype(OP_SLE, 3'd1, 3'd2, 3'd5), 1'b1, 0);
      end
      end_test("compares");

      for (int i = 0; i < STALL_INSTRS; i++) begin
         r = next_rand();
         issue(random_alu(), 1'b1, int'(r[1:0]));
      end
      end_test("random_stall");

      // Non-writing slots mixed with real work
      for (int i = 0; i < 10; i++) begin
         r = next_rand();
         issue(make_rtype(OP_NOP, r[2:0], r[5:3], r[8:6]), 1'b1, 0);
         issue({bad_ops[i % 6], r[20:10]}, 1'b1, 0);
         issue(make_rtype(OP_ADD, r[2:0], r[5:3], r[8:6]), 1'b0, 0);
         issue(random_alu(), 1'b1, 0);
      end
      end_test("no_write");

      $display("Total: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* sim/cpu_core_sva.sv */
// Concurrent checks on the pipeline controls of cpu_core.
// Payloads carry no reset, so their stability is checked only while
// the matching valid bit is set.

`timescale 1ns/1ps

module cpu_core_sva (
   input logic            clk,
   input logic            arst_n,
   input logic            stall,
   input logic            wb_valid,
   input logic            id_ex_valid,
   input logic            ex_wb_valid,
   input cpu_pkg::id_ex_t id_ex_q,
   input cpu_pkg::ex_wb_t ex_wb_q
);

   // Write-back held off during stall
   a_no_wb_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
      stall |-> !wb_valid)
      else $error("wb_valid high while stall is high");

   // Write-back only from a valid EX/WB entry
   a_wb_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
      !ex_wb_valid |-> !wb_valid)
      else $error("wb_valid high with an empty write-back stage");

   // Both stages frozen across a stalled edge
   a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
      stall |=> $stable(id_ex_valid) && $stable(ex_wb_valid)
                && (!id_ex_valid || $stable(id_ex_q))
                && (!ex_wb_valid || $stable(ex_wb_q)))
      else $error("pipeline stage changed during stall");

endmodule

bind cpu_core cpu_core_sva u_cpu_core_sva (
   .clk         (clk),
   .arst_n      (arst_n),
   .stall       (stall),
   .wb_valid    (wb_valid),
   .id_ex_valid (id_ex_valid),
   .ex_wb_valid (ex_wb_valid),
   .id_ex_q     (id_ex_q),
   .ex_wb_q     (ex_wb_q)
);

/* hdl/cpu_core.sv */
// Three-stage pipeline top: decode, execute, write-back.
// Instructions arrive on instr with a one-cycle instr_valid strobe;
// there is no fetch and no data memory.
// stall is a level that freezes both pipeline registers, ignores instr
// and keeps wb_valid low, so no register is written while it is high.

`timescale 1ns/1ps

module cpu_core (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              instr_valid,
   input  cpu_pkg::instr_t   instr,
   input  logic              stall,
   output logic              wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data
);

   import cpu_pkg::*;

   reg_idx_t rd_a;
   reg_idx_t rd_b;
   word_t    data_a;
   word_t    data_b;
   id_ex_t   id_ex_d;
   id_ex_t   id_ex_q;
   logic     id_ex_valid;
   ex_wb_t   ex_wb_d;
   ex_wb_t   ex_wb_q;
   logic     ex_wb_valid;

   // Decode
   instr_decoder u_decoder (
      .instr  (instr),
      .rd_a   (rd_a),
      .rd_b   (rd_b),
      .data_a (data_a),
      .data_b (data_b),
      .id_ex  (id_ex_d)
   );

   reg_file u_reg_file (
      .clk     (clk),
      .arst_n  (arst_n),
      .rd_a    (rd_a),
      .rd_b    (rd_b),
      .wr_en   (wb_valid),
      .wr_idx  (ex_wb_q.rd),
      .wr_data (ex_wb_q.result),
      .data_a  (data_a),
      .data_b  (data_b)
   );

   // A low instr_valid enters as a bubble
   pipe_stage #(.PAYLOAD_T(cpu_pkg::id_ex_t)) u_id_ex (
      .clk       (clk),
      .arst_n    (arst_n),
      .hold      (stall),
      .in_valid  (instr_valid),
      .in_data   (id_ex_d),
      .out_valid (id_ex_valid),
      .out_data  (id_ex_q)
   );

   // Forwarding uses the raw EX/WB valid, which stays set during stall
   alu_execute u_execute (
      .id_ex      (id_ex_q),
      .wb_valid_q (ex_wb_valid),
      .ex_wb_q    (ex_wb_q),
      .ex_wb      (ex_wb_d)
   );

   pipe_stage #(.PAYLOAD_T(cpu_pkg::ex_wb_t)) u_ex_wb (
      .clk       (clk),
      .arst_n    (arst_n),
      .hold      (stall),
      .in_valid  (id_ex_valid),
      .in_data   (ex_wb_d),
      .out_valid (ex_wb_valid),
      .out_data  (ex_wb_q)
   );

   // Write-back
   assign wb_valid = ex_wb_valid && ex_wb_q.reg_wrt && !stall;
   assign wb_reg   = ex_wb_q.rd;
   assign wb_data  = ex_wb_q.result;

endmodule

/* hdl/alu_execute.sv */
// Combinational execute stage.
// Forwards the EX/WB result when the older instruction writes a
// register read here; instructions two apart rely on the register
// file write-through instead.
// Compares are signed and give 1 or 0.

`timescale 1ns/1ps

module alu_execute (
   input  cpu_pkg::id_ex_t id_ex,
   input  logic            wb_valid_q,
   input  cpu_pkg::ex_wb_t ex_wb_q,
   output cpu_pkg::ex_wb_t ex_wb
);

   import cpu_pkg::*;

   logic  older_wr;
   logic  fwd_a;
   logic  fwd_b;
   word_t a;
   word_t b;
   word_t sum;
   word_t diff;
   logic  eq;
   logic  lt;
   word_t result;

   // Older instruction still in EX/WB and writing
   assign older_wr = wb_valid_q && ex_wb_q.reg_wrt;

   assign fwd_a = older_wr && (ex_wb_q.rd == id_ex.rs);
   // Immediate forms never read rt
   assign fwd_b = older_wr && !id_ex.use_imm && (ex_wb_q.rd == id_ex.rt);

   assign a = fwd_a ? ex_wb_q.result : id_ex.operand_a;
   assign b = fwd_b ? ex_wb_q.result : id_ex.operand_b;

   assign sum  = a + b;
   assign diff = b - a;
   assign eq   = (a == b);
   assign lt   = ($signed(a) < $signed(b));

   always_comb begin
      case (id_ex.alu_sel)
         SEL_SUM: begin
            result = sum;
         end
         SEL_DIFF: begin
            result = diff;
         end
         SEL_XOR: begin
            result = a ^ b;
         end
         SEL_ANDN: begin
            result = a & ~b;
         end
         SEL_LBI: begin
            result = b;
         end
         SEL_SLBI: begin
            result = (a << 8) | {8'h00, b[7:0]};
         end
         SEL_SEQ: begin
            result = {15'b0, eq};
         end
         SEL_SLT: begin
            result = {15'b0, lt};
         end
         SEL_SLE: begin
            result = {15'b0, lt | eq};
         end
         default: begin
            result = '0;
         end
      endcase
   end

   assign ex_wb.rd      = id_ex.rd;
   assign ex_wb.reg_wrt = id_ex.reg_wrt;
   assign ex_wb.result  = result;

endmodule

/* hdl/pipe_stage.sv */
// Pipeline register with a valid bit, typed by its payload.
// While hold is high both payload and valid keep their value.
// Only the valid bit is reset.

`timescale 1ns/1ps

module pipe_stage #(
   parameter type PAYLOAD_T = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     hold,
   input  logic     in_valid,
   input  PAYLOAD_T in_data,
   output logic     out_valid,
   output PAYLOAD_T out_data
);

   logic     valid_q;
   PAYLOAD_T data_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (!hold) begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         data_q <= in_data;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

/* hdl/instr_decoder.sv */
// Combinational decode of one instruction into the ID/EX payload.
// Register reads always use bits 10:8 and 7:5; operand_b is replaced
// by the sign-extended immediate for ADDI, LBI and SLBI.
// NOP and unknown opcodes leave reg_wrt low.

`timescale 1ns/1ps

module instr_decoder (
   input  cpu_pkg::instr_t   instr,
   output cpu_pkg::reg_idx_t rd_a,
   output cpu_pkg::reg_idx_t rd_b,
   input  cpu_pkg::word_t    data_a,
   input  cpu_pkg::word_t    data_b,
   output cpu_pkg::id_ex_t   id_ex
);

   import cpu_pkg::*;

   opcode_e  opcode;
   reg_idx_t rs;
   reg_idx_t rt;
   word_t    imm5_sext;
   word_t    imm8_sext;

   assign opcode    = opcode_e'(instr[15:11]);
   assign rs        = instr[10:8];
   assign rt        = instr[7:5];
   assign imm5_sext = {{11{instr[4]}}, instr[4:0]};
   assign imm8_sext = {{8{instr[7]}}, instr[7:0]};

   assign rd_a = rs;
   assign rd_b = rt;

   always_comb begin
      // R-type defaults
      id_ex.alu_sel   = SEL_SUM;
      id_ex.rs        = rs;
      id_ex.rt        = rt;
      id_ex.rd        = instr[4:2];
      id_ex.reg_wrt   = 1'b0;
      id_ex.operand_a = data_a;
      id_ex.operand_b = data_b;
      id_ex.use_imm   = 1'b0;

      case (opcode)
         OP_ADD: begin
            id_ex.alu_sel = SEL_SUM;
            id_ex.reg_wrt = 1'b1;
         end
         OP_SUB: begin
            id_ex.alu_sel = SEL_DIFF;
            id_ex.reg_wrt = 1'b1;
         end
         OP_XOR: begin
            id_ex.alu_sel = SEL_XOR;
            id_ex.reg_wrt = 1'b1;
         end
         OP_ANDN: begin
            id_ex.alu_sel = SEL_ANDN;
            id_ex.reg_wrt = 1'b1;
         end
         OP_SEQ: begin
            id_ex.alu_sel = SEL_SEQ;
            id_ex.reg_wrt = 1'b1;
         end
         OP_SLT: begin
            id_ex.alu_sel = SEL_SLT;
            id_ex.reg_wrt = 1'b1;
         end
         OP_SLE: begin
            id_ex.alu_sel = SEL_SLE;
            id_ex.reg_wrt = 1'b1;
         end
         OP_ADDI: begin
            // Destination sits where rt would be
            id_ex.alu_sel   = SEL_SUM;
            id_ex.rd        = rt;
            id_ex.operand_b = imm5_sext;
            id_ex.use_imm   = 1'b1;
            id_ex.reg_wrt   = 1'b1;
         end
         OP_LBI: begin
            id_ex.alu_sel   = SEL_LBI;
            id_ex.rd        = rs;
            id_ex.operand_b = imm8_sext;
            id_ex.use_imm   = 1'b1;
            id_ex.reg_wrt   = 1'b1;
         end
         OP_SLBI: begin
            // Old rs value shifts up, so operand_a stays the register
            id_ex.alu_sel   = SEL_SLBI;
            id_ex.rd        = rs;
            id_ex.operand_b = imm8_sext;
            id_ex.use_imm   = 1'b1;
            id_ex.reg_wrt   = 1'b1;
         end
         OP_NOP: begin
            id_ex.reg_wrt = 1'b0;
         end
         default: begin
            id_ex.reg_wrt = 1'b0;
         end
      endcase
   end

endmodule

/* hdl/reg_file.sv */
// Eight 16-bit registers, two combinational read ports, one write port.
// A read of the register written in the same cycle returns the new
// value, so decode sees results two instructions back.
// All registers clear on reset.

`timescale 1ns/1ps

module reg_file (
   input  logic             clk,
   input  logic             arst_n,
   input  cpu_pkg::reg_idx_t rd_a,
   input  cpu_pkg::reg_idx_t rd_b,
   input  logic             wr_en,
   input  cpu_pkg::reg_idx_t wr_idx,
   input  cpu_pkg::word_t    wr_data,
   output cpu_pkg::word_t    data_a,
   output cpu_pkg::word_t    data_b
);

   import cpu_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Write-through bypass
   always_comb begin
      if (wr_en && (wr_idx == rd_a)) begin
         data_a = wr_data;
      end else begin
         data_a = regs[rd_a];
      end
   end

   always_comb begin
      if (wr_en && (wr_idx == rd_b)) begin
         data_b = wr_data;
      end else begin
         data_b = regs[rd_b];
      end
   end

endmodule

/* hdl/cpu_pkg.sv */
// Shared types for the three-stage 16-bit integer pipeline.
// Eight registers, 5-bit opcodes in bits 15:11.
// Opcode codes outside opcode_e decode as a NOP.
// Stage payloads are packed structs carried by pipe_stage.

package cpu_pkg;

   localparam int NUM_REGS = 8;

   typedef logic [15:0] word_t;
   typedef logic [15:0] instr_t;
   typedef logic [2:0]  reg_idx_t;

   // Instruction opcodes, bits 15:11
   typedef enum logic [4:0] {
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_SLBI = 5'b10010,
      OP_ANDN = 5'b10111,
      OP_LBI  = 5'b11000,
      OP_SUB  = 5'b11001,
      OP_XOR  = 5'b11010,
      OP_ADD  = 5'b11011,
      OP_SEQ  = 5'b11100,
      OP_SLT  = 5'b11101,
      OP_SLE  = 5'b11110
   } opcode_e;

   // Execute result select
   typedef enum logic [3:0] {
      SEL_SUM  = 4'd0,
      SEL_DIFF = 4'd1,
      SEL_XOR  = 4'd2,
      SEL_ANDN = 4'd3,
      SEL_LBI  = 4'd4,
      SEL_SLBI = 4'd5,
      SEL_SEQ  = 4'd6,
      SEL_SLT  = 4'd7,
      SEL_SLE  = 4'd8
   } alu_sel_e;

   // Decode to execute
   typedef struct packed {
      alu_sel_e alu_sel;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic     reg_wrt;
      word_t    operand_a;
      // Holds the immediate for ADDI, LBI and SLBI
      word_t    operand_b;
      logic     use_imm;
   } id_ex_t;

   // Execute to write-back
   typedef struct packed {
      reg_idx_t rd;
      logic     reg_wrt;
      word_t    result;
   } ex_wb_t;

endpackage
